// File: files.f
+incdir+.
red_pkg.sv
narrow_reduction_alu.sv
wide_dca_translator.sv
wide_dca_unit.sv
reduction_offload_tile.sv
red_assertions.sv
tb_clock_gen.sv
tb_reduction_offload.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f files.f --top-module tb_reduction_offload -o sim_tb \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "All checks passed" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// File: tb_reduction_offload.sv
// Testbench for the reduction offload tile
// Directed table, random requests with back-pressure, wide stream and burst timing

`timescale 1ns/100ps

`include "red_macros.svh"

module tb_reduction_offload;

  logic clk;
  logic rst_n;
  red_pkg::reduction_op_e   n_op;
  red_pkg::reduction_op_e   w_op;
  logic [`RED_NARROW_W-1:0] n_a;
  logic [`RED_NARROW_W-1:0] n_b;
  logic [`RED_NARROW_W-1:0] n_res;
  logic [`RED_WIDE_W-1:0]   w_a;
  logic [`RED_WIDE_W-1:0]   w_b;
  logic [`RED_WIDE_W-1:0]   w_res;
  logic n_val;
  logic n_rdy;
  logic n_rvalid;
  logic n_rrdy;
  logic w_val;
  logic w_rdy;
  logic w_rvalid;
  logic w_rrdy;

  int          cycle = 0;
  int          errors;
  int          tests;
  logic [63:0] rng;

  // Directed table
  bit                     tbl_wide [12];
  logic [2:0]             tbl_op   [12];
  logic [`RED_WIDE_W-1:0] tbl_a    [12];
  logic [`RED_WIDE_W-1:0] tbl_b    [12];
  logic [`RED_WIDE_W-1:0] tbl_exp  [12];

  tb_clock_gen clock_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

  reduction_offload_tile reduction_offload_tile_inst (
    .clk_i(clk), .rst_n_i(rst_n),
    .narrow_req_op_i(n_op), .narrow_req_operand1_i(n_a), .narrow_req_operand2_i(n_b),
    .narrow_req_valid_i(n_val), .narrow_req_ready_o(n_rdy),
    .narrow_resp_result_o(n_res), .narrow_resp_valid_o(n_rvalid),
    .narrow_resp_ready_i(n_rrdy),
    .wide_req_op_i(w_op), .wide_req_operand1_i(w_a), .wide_req_operand2_i(w_b),
    .wide_req_valid_i(w_val), .wide_req_ready_o(w_rdy),
    .wide_resp_result_o(w_res), .wide_resp_valid_o(w_rvalid),
    .wide_resp_ready_i(w_rrdy)
  );

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  // Expected results from the operation rules
  function automatic logic [63:0] lane_model(input logic [2:0] op, input logic [63:0] a,
                                             input logic [63:0] b);
    case (op)
      3'd0: return a + b;
      3'd1: return a * b;
      3'd2: return ($signed(a) > $signed(b)) ? a : b;
      3'd3: return ($signed(a) < $signed(b)) ? a : b;
      default: return 64'd0;
    endcase
  endfunction

  function automatic logic [`RED_WIDE_W-1:0] expected(input bit wide, input logic [2:0] op,
                                                      input logic [`RED_WIDE_W-1:0] a,
                                                      input logic [`RED_WIDE_W-1:0] b);
    logic [`RED_WIDE_W-1:0] r;
    logic [31:0]            n;
    r = '0;
    if (wide) begin
      for (int l = 0; l < `RED_LANES; l++) begin
        r[l*64 +: 64] = lane_model(op, a[l*64 +: 64], b[l*64 +: 64]);
      end
    end else begin
      // Sign-extend to reuse the lane rules, keep the low word
      n = 32'(lane_model(op, {{32{a[31]}}, a[31:0]}, {{32{b[31]}}, b[31:0]}));
      r = {224'b0, n};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [`RED_WIDE_W-1:0] exp,
                             input logic [`RED_WIDE_W-1:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic timeout(input string what, input string name);
    $display("Timeout while waiting for %s in test %s", what, name);
    $display("Checks failed");
    $finish;
  endtask

  task automatic set_resp_ready(input bit random_bp);
    rng = xorshift(rng);
    n_rrdy = random_bp ? rng[5] : 1'b1;
    w_rrdy = n_rrdy;
  endtask

  task automatic set_entry(input int i, input bit wide, input logic [2:0] op,
                           input logic [`RED_WIDE_W-1:0] a, input logic [`RED_WIDE_W-1:0] b,
                           input logic [`RED_WIDE_W-1:0] exp);
    tbl_wide[i] = wide;
    tbl_op[i]   = op;
    tbl_a[i]    = a;
    tbl_b[i]    = b;
    tbl_exp[i]  = exp;
  endtask

  task automatic load_table();
    logic [`RED_WIDE_W-1:0] ma;
    logic [`RED_WIDE_W-1:0] mb;
    ma = {64'hFFFFFFFFFFFFFFFF, 64'd5, 64'hFFFFFFFFFFFFFF9C, 64'd0};
    mb = {64'd1, 64'hFFFFFFFFFFFFFFFB, 64'hFFFFFFFFFFFFFF38, 64'd0};
    set_entry(0, 0, 3'd0, 256'd5, 256'd7, 256'd12);
    set_entry(1, 0, 3'd0, 256'hFFFFFFFD, 256'd1, 256'hFFFFFFFE);
    set_entry(2, 0, 3'd1, 256'h12345678, 256'd16, 256'h23456780);
    set_entry(3, 0, 3'd1, 256'hFFFFFFFE, 256'd3, 256'hFFFFFFFA);
    set_entry(4, 0, 3'd2, 256'hFFFFFFFB, 256'd3, 256'd3);
    set_entry(5, 0, 3'd3, 256'hFFFFFFFB, 256'd3, 256'hFFFFFFFB);
    set_entry(6, 0, 3'd5, 256'd9, 256'd9, 256'd0);
    set_entry(7, 1, 3'd0,
              {64'd1, 64'hFFFFFFFFFFFFFFFF, 64'd100, 64'h7FFFFFFFFFFFFFFF},
              {64'd2, 64'd1, 64'hFFFFFFFFFFFFFFCE, 64'd1},
              {64'd3, 64'd0, 64'd50, 64'h8000000000000000});
    set_entry(8, 1, 3'd1,
              {64'd3, 64'hFFFFFFFFFFFFFFFE, 64'h100000000, 64'd7},
              {64'd4, 64'd5, 64'h100000000, 64'hFFFFFFFFFFFFFFFF},
              {64'd12, 64'hFFFFFFFFFFFFFFF6, 64'd0, 64'hFFFFFFFFFFFFFFF9});
    set_entry(9, 1, 3'd2, ma, mb, {64'd1, 64'd5, 64'hFFFFFFFFFFFFFF9C, 64'd0});
    set_entry(10, 1, 3'd3, ma, mb,
              {64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFB, 64'hFFFFFFFFFFFFFF38, 64'd0});
    set_entry(11, 1, 3'd7, ma, mb, 256'd0);
  endtask

  // One request, one response; latency checked when never stalled
  task automatic run_test(input string name, input bit wide, input logic [2:0] op,
                          input logic [`RED_WIDE_W-1:0] a, input logic [`RED_WIDE_W-1:0] b,
                          input logic [`RED_WIDE_W-1:0] exp, input bit random_bp);
    int  t;
    int  acc;
    bit  done;
    bit  seen;
    logic vld;
    @(posedge clk);
    #1;
    if (wide) begin
      w_op = red_pkg::reduction_op_e'(op);
      w_a = a;
      w_b = b;
      w_val = 1'b1;
    end else begin
      n_op = red_pkg::reduction_op_e'(op);
      n_a = a[31:0];
      n_b = b[31:0];
      n_val = 1'b1;
    end
    set_resp_ready(random_bp);
    #1;
    t = 0;
    while (!(wide ? w_rdy : n_rdy)) begin
      t++;
      if (t > 100) timeout("request ready", name);
      @(posedge clk);
      #1;
      set_resp_ready(random_bp);
      #1;
    end
    acc = cycle;
    @(posedge clk);
    #1;
    n_val = 1'b0;
    w_val = 1'b0;
    set_resp_ready(random_bp);
    t = 0;
    done = 0;
    seen = 0;
    while (!done) begin
      vld = wide ? w_rvalid : n_rvalid;
      if (vld) begin
        check_value(name, exp, wide ? w_res : {224'b0, n_res});
        if (!random_bp && !seen) begin
          check_value({name, " latency"}, wide ? 256'd2 : 256'd1, 256'(cycle - acc));
        end
        seen = 1;
        done = n_rrdy;
      end
      if (!done) begin
        t++;
        if (t > 200) timeout("response valid", name);
        @(posedge clk);
        #1;
        set_resp_ready(random_bp);
      end
    end
    @(posedge clk);
    #1;
    vld = wide ? w_rvalid : n_rvalid;
    check_value({name, " single response"}, 256'd0, {255'b0, vld});
    set_resp_ready(0);
    tests++;
    $display("test %s done", name);
  endtask

  ////////////////////////////////////////
  // Wide stream with back-pressure
  ////////////////////////////////////////

  // Two items in flight, responses checked in request order
  task automatic run_wide_stream(input int count);
    logic [`RED_WIDE_W-1:0] exp_q [$];
    logic [`RED_WIDE_W-1:0] exp;
    int                     sent;
    int                     got;
    int                     t;
    bit                     req_done;
    bit                     resp_done;
    sent = 0;
    got = 0;
    t = 0;
    req_done = 0;
    while (got < count) begin
      t++;
      if (t > 50 * count) timeout("wide stream response", "wide stream");
      @(posedge clk);
      #1;
      if (req_done) w_val = 1'b0;
      if (!w_val && sent < count) begin
        rng = xorshift(rng);
        w_op = red_pkg::reduction_op_e'(rng[2:0]);
        w_a = {rng, ~rng, xorshift(rng), rng ^ 64'hC3C3};
        w_b = {xorshift(~rng), rng + 64'd7, ~rng, rng};
        exp_q.push_back(expected(1, rng[2:0], w_a, w_b));
        w_val = 1'b1;
        sent++;
      end
      set_resp_ready(1);
      #1;
      req_done = w_val && w_rdy;
      resp_done = w_rvalid && w_rrdy;
      if (resp_done) begin
        if (exp_q.size() == 0) begin
          $display("Wide response arrived with no request outstanding");
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check_value($sformatf("wide stream %0d", got), exp, w_res);
        end
        got++;
      end
    end
    set_resp_ready(0);
    tests++;
    $display("test wide stream done");
  endtask

  ////////////////////////////////////////
  // Back-to-back wide burst
  ////////////////////////////////////////

  task automatic run_burst();
    logic [`RED_WIDE_W-1:0] exp_q [4];
    for (int k = 0; k < 6; k++) begin
      @(posedge clk);
      #1;
      if (k < 4) begin
        rng = xorshift(rng);
        w_op = red_pkg::reduction_op_e'(rng[2:0] & 3'd3);
        w_a = {rng, xorshift(rng), rng ^ 64'h5A5A, ~rng};
        w_b = {~rng, rng, xorshift(~rng), rng + 64'd1};
        exp_q[k] = expected(1, 3'(w_op), w_a, w_b);
        w_val = 1'b1;
        check_value("burst ready", 256'd1, {255'b0, w_rdy});
      end else begin
        w_val = 1'b0;
      end
      check_value("burst valid", {255'b0, k >= 2}, {255'b0, w_rvalid});
      if (k >= 2) check_value("burst result", exp_q[k-2], w_res);
    end
    tests++;
    $display("test wide burst done");
  endtask

  initial begin
    logic [`RED_WIDE_W-1:0] ra;
    logic [`RED_WIDE_W-1:0] rb;
    bit                     rwide;
    logic [2:0]             rop;
    int                     t;
    rng = 64'd19275;
    errors = 0;
    tests = 0;
    n_op = red_pkg::RED_ADD;
    w_op = red_pkg::RED_ADD;
    n_a = '0;
    n_b = '0;
    w_a = '0;
    w_b = '0;
    n_val = 1'b0;
    w_val = 1'b0;
    n_rrdy = 1'b1;
    w_rrdy = 1'b1;
    load_table();
    t = 0;
    while (!rst_n) begin
      t++;
      if (t > 100) timeout("reset release", "reset");
      @(posedge clk);
    end
    #1;
    check_value("reset state", 256'b0110,
                {252'b0, n_rvalid, n_rdy, w_rdy, w_rvalid});
    tests++;
    $display("test reset state done");
    for (int i = 0; i < 12; i++) begin
      run_test($sformatf("table %0d", i), tbl_wide[i], tbl_op[i], tbl_a[i], tbl_b[i],
               tbl_exp[i], 0);
    end
    // Random requests, random back-pressure
    for (int i = 0; i < 40; i++) begin
      rng = xorshift(rng);
      rwide = rng[7];
      rop = rng[2:0];
      ra = {xorshift(rng), rng, xorshift(~rng), ~rng};
      rng = xorshift(rng);
      rb = {rng, xorshift(rng), ~rng, xorshift(~rng)};
      run_test($sformatf("random %0d", i), rwide, rop, ra, rb, expected(rwide, rop, ra, rb), 1);
    end
    run_wide_stream(24);
    run_burst();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset
// 4 ns clock, reset held low for 16 cycles

`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

// File: red_assertions.sv
// Concurrent assertions for the reduction offload tile
// Response stability under back-pressure and reset state

`timescale 1ns/100ps

`include "red_macros.svh"

module red_reduction_assertions (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     narrow_req_ready_o,
  input logic [`RED_NARROW_W-1:0] narrow_resp_result_o,
  input logic                     narrow_resp_valid_o,
  input logic                     narrow_resp_ready_i,
  input logic                     wide_req_ready_o,
  input logic [`RED_WIDE_W-1:0]   wide_resp_result_o,
  input logic                     wide_resp_valid_o,
  input logic                     wide_resp_ready_i
);

  // Stalled responses hold valid and data
  narrow_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    narrow_resp_valid_o && !narrow_resp_ready_i |=>
    narrow_resp_valid_o && $stable(narrow_resp_result_o))
    else $error("narrow response changed while stalled");

  wide_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wide_resp_valid_o && !wide_resp_ready_i |=>
    wide_resp_valid_o && $stable(wide_resp_result_o))
    else $error("wide response changed while stalled");

  // Reset clears both pipelines
  reset_state: assert property (@(posedge clk_i)
    !rst_n_i |=> !narrow_resp_valid_o && !wide_resp_valid_o &&
    narrow_req_ready_o && wide_req_ready_o)
    else $error("bad state after reset");

endmodule

bind reduction_offload_tile red_reduction_assertions red_assertions_inst (.*);

// File: reduction_offload_tile.sv
// Reduction offload tile top level
// Narrow ALU port, wide translator and wide compute unit

`timescale 1ns/100ps

`include "red_macros.svh"

module reduction_offload_tile (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Narrow offload port
  input  red_pkg::reduction_op_e     narrow_req_op_i,
  input  logic [`RED_NARROW_W-1:0]   narrow_req_operand1_i,
  input  logic [`RED_NARROW_W-1:0]   narrow_req_operand2_i,
  input  logic                       narrow_req_valid_i,
  output logic                       narrow_req_ready_o,
  output logic [`RED_NARROW_W-1:0]   narrow_resp_result_o,
  output logic                       narrow_resp_valid_o,
  input  logic                       narrow_resp_ready_i,
  // Wide offload port
  input  red_pkg::reduction_op_e     wide_req_op_i,
  input  logic [`RED_WIDE_W-1:0]     wide_req_operand1_i,
  input  logic [`RED_WIDE_W-1:0]     wide_req_operand2_i,
  input  logic                       wide_req_valid_i,
  output logic                       wide_req_ready_o,
  output logic [`RED_WIDE_W-1:0]     wide_resp_result_o,
  output logic                       wide_resp_valid_o,
  input  logic                       wide_resp_ready_i
);

  // Translator to compute unit
  red_pkg::dca_op_e        dca_op;
  red_pkg::dca_mode_e      dca_mode;
  logic [`RED_WIDE_W-1:0]  dca_operand0;
  logic [`RED_WIDE_W-1:0]  dca_operand1;
  logic [`RED_WIDE_W-1:0]  dca_operand2;
  logic                    dca_req_valid;
  logic                    dca_req_ready;

  narrow_reduction_alu narrow_alu_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_op_i       (narrow_req_op_i),
    .req_operand1_i (narrow_req_operand1_i),
    .req_operand2_i (narrow_req_operand2_i),
    .req_valid_i    (narrow_req_valid_i),
    .req_ready_o    (narrow_req_ready_o),
    .resp_result_o  (narrow_resp_result_o),
    .resp_valid_o   (narrow_resp_valid_o),
    .resp_ready_i   (narrow_resp_ready_i)
  );

  wide_dca_translator wide_translator_inst (
    .req_op_i       (wide_req_op_i),
    .req_operand1_i (wide_req_operand1_i),
    .req_operand2_i (wide_req_operand2_i),
    .req_valid_i    (wide_req_valid_i),
    .req_ready_o    (wide_req_ready_o),
    .dca_op_o       (dca_op),
    .dca_mode_o     (dca_mode),
    .dca_operand0_o (dca_operand0),
    .dca_operand1_o (dca_operand1),
    .dca_operand2_o (dca_operand2),
    .dca_valid_o    (dca_req_valid),
    .dca_ready_i    (dca_req_ready)
  );

  wide_dca_unit wide_unit_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dca_op_i       (dca_op),
    .dca_mode_i     (dca_mode),
    .dca_operand0_i (dca_operand0),
    .dca_operand1_i (dca_operand1),
    .dca_operand2_i (dca_operand2),
    .dca_valid_i    (dca_req_valid),
    .dca_ready_o    (dca_req_ready),
    .resp_result_o  (wide_resp_result_o),
    .resp_valid_o   (wide_resp_valid_o),
    .resp_ready_i   (wide_resp_ready_i)
  );

endmodule

// File: wide_dca_unit.sv
// Wide compute unit
// Two-stage pipeline over four signed 64-bit lanes, stalls on back-pressure

`timescale 1ns/100ps

`include "red_macros.svh"

module wide_dca_unit (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Command
  input  red_pkg::dca_op_e         dca_op_i,
  input  red_pkg::dca_mode_e       dca_mode_i,
  input  logic [`RED_WIDE_W-1:0]   dca_operand0_i,
  input  logic [`RED_WIDE_W-1:0]   dca_operand1_i,
  input  logic [`RED_WIDE_W-1:0]   dca_operand2_i,
  input  logic                     dca_valid_i,
  output logic                     dca_ready_o,
  // Response
  output logic [`RED_WIDE_W-1:0]   resp_result_o,
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i
);

  // Stage one command
  red_pkg::dca_op_e         s1_op_q;
  red_pkg::dca_mode_e       s1_mode_q;
  logic [`RED_WIDE_W-1:0]   s1_operand0_q;
  logic [`RED_WIDE_W-1:0]   s1_operand1_q;
  logic [`RED_WIDE_W-1:0]   s1_operand2_q;
  logic                     s1_valid_q;

  // Stage two result
  logic [`RED_WIDE_W-1:0]   lane_result;
  logic [`RED_WIDE_W-1:0]   s2_result_q;
  logic                     s2_valid_q;

  logic                     stall;
  logic                     s1_load;

  assign stall       = s2_valid_q && !resp_ready_i;
  // Stage one can still fill a bubble during a stall
  assign dca_ready_o = !(stall && s1_valid_q);
  assign s1_load     = dca_valid_i && dca_ready_o;

  ////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else if (!stall || !s1_valid_q) begin
      s1_valid_q <= dca_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_load) begin
      s1_op_q       <= dca_op_i;
      s1_mode_q     <= dca_mode_i;
      s1_operand0_q <= dca_operand0_i;
      s1_operand1_q <= dca_operand1_i;
      s1_operand2_q <= dca_operand2_i;
    end
  end

  ////////////////////////////////////////
  // Lane compute
  ////////////////////////////////////////

  always_comb begin
    logic signed [`RED_LANE_W-1:0] a;
    logic signed [`RED_LANE_W-1:0] b;
    logic signed [`RED_LANE_W-1:0] c;
    lane_result = '0;
    for (int l = 0; l < `RED_LANES; l++) begin
      a = s1_operand0_q[l*`RED_LANE_W +: `RED_LANE_W];
      b = s1_operand1_q[l*`RED_LANE_W +: `RED_LANE_W];
      c = s1_operand2_q[l*`RED_LANE_W +: `RED_LANE_W];
      case (s1_op_q)
        red_pkg::DCA_ADD:    lane_result[l*`RED_LANE_W +: `RED_LANE_W] = b + c;
        red_pkg::DCA_MUL:    lane_result[l*`RED_LANE_W +: `RED_LANE_W] = a * b;
        red_pkg::DCA_MINMAX: begin
          if (s1_mode_q == red_pkg::DCA_SEL_MIN) begin
            lane_result[l*`RED_LANE_W +: `RED_LANE_W] = (a < b) ? a : b;
          end else begin
            lane_result[l*`RED_LANE_W +: `RED_LANE_W] = (a > b) ? a : b;
          end
        end
        default:             lane_result[l*`RED_LANE_W +: `RED_LANE_W] = '0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s2_valid_q <= 1'b0;
    end else if (!stall) begin
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall && s1_valid_q) begin
      s2_result_q <= lane_result;
    end
  end

  assign resp_result_o = s2_result_q;
  assign resp_valid_o  = s2_valid_q;

endmodule

// File: wide_dca_translator.sv
// Wide request translator
// Maps a reduction operation onto a compute-unit command and operand slots

`timescale 1ns/100ps

`include "red_macros.svh"

module wide_dca_translator (
  // Wide reduction request
  input  red_pkg::reduction_op_e   req_op_i,
  input  logic [`RED_WIDE_W-1:0]   req_operand1_i,
  input  logic [`RED_WIDE_W-1:0]   req_operand2_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  // Compute-unit command
  output red_pkg::dca_op_e         dca_op_o,
  output red_pkg::dca_mode_e       dca_mode_o,
  output logic [`RED_WIDE_W-1:0]   dca_operand0_o,
  output logic [`RED_WIDE_W-1:0]   dca_operand1_o,
  output logic [`RED_WIDE_W-1:0]   dca_operand2_o,
  output logic                     dca_valid_o,
  input  logic                     dca_ready_i
);

  // Handshake passes straight through
  assign dca_valid_o = req_valid_i;
  assign req_ready_o = dca_ready_i;

  always_comb begin
    dca_op_o       = red_pkg::DCA_ADD;
    dca_mode_o     = red_pkg::DCA_SEL_MAX;
    dca_operand0_o = '0;
    dca_operand1_o = '0;
    dca_operand2_o = '0;

    case (req_op_i)
      // Add reads slots 1 and 2
      red_pkg::RED_ADD: begin
        dca_operand1_o = req_operand1_i;
        dca_operand2_o = req_operand2_i;
      end
      red_pkg::RED_MUL: begin
        dca_op_o       = red_pkg::DCA_MUL;
        dca_operand0_o = req_operand1_i;
        dca_operand1_o = req_operand2_i;
      end
      red_pkg::RED_MAX: begin
        dca_op_o       = red_pkg::DCA_MINMAX;
        dca_operand0_o = req_operand1_i;
        dca_operand1_o = req_operand2_i;
      end
      red_pkg::RED_MIN: begin
        dca_op_o       = red_pkg::DCA_MINMAX;
        dca_mode_o     = red_pkg::DCA_SEL_MIN;
        dca_operand0_o = req_operand1_i;
        dca_operand1_o = req_operand2_i;
      end
      default: begin
        // Unknown op, add of zeros
      end
    endcase
  end

endmodule

// File: narrow_reduction_alu.sv
// Narrow reduction ALU
// 32-bit add, low-half mul, signed max and min behind a response register

`timescale 1ns/100ps

`include "red_macros.svh"

module narrow_reduction_alu (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Request
  input  red_pkg::reduction_op_e     req_op_i,
  input  logic [`RED_NARROW_W-1:0]   req_operand1_i,
  input  logic [`RED_NARROW_W-1:0]   req_operand2_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  // Response
  output logic [`RED_NARROW_W-1:0]   resp_result_o,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i
);

  logic [`RED_NARROW_W-1:0] result_d;
  logic [`RED_NARROW_W-1:0] result_q;
  logic                     valid_q;
  logic                     accept;

  // Room when empty or drained this cycle
  assign req_ready_o = !valid_q || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  ////////////////////////////////////////
  // Compute
  ////////////////////////////////////////

  always_comb begin
    case (req_op_i)
      red_pkg::RED_ADD: begin
        result_d = req_operand1_i + req_operand2_i;
      end
      red_pkg::RED_MUL: begin
        // Low half of the product
        result_d = req_operand1_i * req_operand2_i;
      end
      red_pkg::RED_MAX: begin
        result_d = ($signed(req_operand1_i) > $signed(req_operand2_i)) ?
                   req_operand1_i : req_operand2_i;
      end
      red_pkg::RED_MIN: begin
        result_d = ($signed(req_operand1_i) < $signed(req_operand2_i)) ?
                   req_operand1_i : req_operand2_i;
      end
      default: begin
        result_d = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Response register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Held while stalled
  always_ff @(posedge clk_i) begin
    if (accept) begin
      result_q <= result_d;
    end
  end

  assign resp_result_o = result_q;
  assign resp_valid_o  = valid_q;

endmodule

// File: red_pkg.sv
// Shared types of the reduction offload tile
// Reduction operation, compute-unit opcode and min/max selector

`include "red_macros.svh"

package red_pkg;

  ////////////////////////////////////////
  // Reduction request
  ////////////////////////////////////////

  // Codes 4 to 7 are invalid and give a zero result
  typedef enum logic [`RED_OP_W-1:0] {
    RED_ADD = 3'd0,
    RED_MUL = 3'd1,
    RED_MAX = 3'd2,
    RED_MIN = 3'd3
  } reduction_op_e;

  ////////////////////////////////////////
  // Wide compute unit command
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    DCA_ADD    = 2'd0,
    DCA_MUL    = 2'd1,
    DCA_MINMAX = 2'd2
  } dca_op_e;

  typedef enum logic {
    DCA_SEL_MAX = 1'b0,
    DCA_SEL_MIN = 1'b1
  } dca_mode_e;

endpackage

// File: red_macros.svh
// Width macros for the reduction offload tile
// Narrow word, wide word, lane and operation code

`ifndef RED_MACROS_SVH
`define RED_MACROS_SVH

////////////////////////////////////////
// Data widths
////////////////////////////////////////

// Narrow operand and result
`define RED_NARROW_W 32

// Wide operand, split into signed lanes
`define RED_WIDE_W 256
`define RED_LANE_W 64
`define RED_LANES 4

// Reduction operation code
`define RED_OP_W 3

`endif
